//--- flist.f
hdl/calc_pkg.sv
hdl/calc_bypass.sv
hdl/calc_pipe_ctrl.sv
hdl/calc_pipe_int.sv
hdl/calc_pipe_mul.sv
hdl/calc_stage_pipe.sv
hdl/calc_top.sv
verif/tb_calc_top.sv

//--- Bender.yml
package:
  name: calc_backend

sources:
  - files:
      - hdl/calc_pkg.sv
      - hdl/calc_bypass.sv
      - hdl/calc_pipe_ctrl.sv
      - hdl/calc_pipe_int.sv
      - hdl/calc_pipe_mul.sv
      - hdl/calc_stage_pipe.sv
      - hdl/calc_top.sv
  - target: simulation
    files:
      - verif/tb_calc_top.sv

//--- verif/tb_calc_top.sv
/* Directed testbench for calc_top with a register file reference model.
   Stimulus keeps mul dependents at least two dispatch cycles behind the mul. */
`timescale 1ns/10ps

module tb_calc_top
  import calc_pkg::*;
();

  localparam int clk_period_lp    = 8;
  localparam int reset_cycles_lp  = 16;
  localparam int ring_lp          = 8;
  // Cycle budgets of reset/x0, ALU chain, mul, branch and flush tests
  localparam int test_cycles_lp   = reset_cycles_lp + 10 + 40 + 18 + 20 + 14;
  localparam int margin_cycles_lp = 64;
  localparam int timeout_ns_lp    = (test_cycles_lp + margin_cycles_lp) * clk_period_lp;

  logic                         clk_i;
  logic                         rst_i;
  logic                         flush_i;
  logic                         dispatch_v_i;
  calc_op_e                     dispatch_op_i;
  logic [vaddr_width_lp-1:0]    dispatch_pc_i;
  logic [reg_addr_width_lp-1:0] dispatch_rs1_addr_i;
  logic [reg_addr_width_lp-1:0] dispatch_rs2_addr_i;
  logic [reg_addr_width_lp-1:0] dispatch_rd_addr_i;
  logic [dword_width_lp-1:0]    dispatch_rs1_data_i;
  logic [dword_width_lp-1:0]    dispatch_rs2_data_i;
  logic [dword_width_lp-1:0]    dispatch_imm_i;
  logic                         br_v_o;
  logic                         btaken_o;
  logic [vaddr_width_lp-1:0]    br_tgt_o;
  logic                         commit_v_o;
  logic [vaddr_width_lp-1:0]    commit_pc_o;
  logic                         wb_v_o;
  logic [reg_addr_width_lp-1:0] wb_addr_o;
  logic [dword_width_lp-1:0]    wb_data_o;

  calc_top uut (.*);

  // Values in program order, and the register file as the dispatcher sees it
  logic [dword_width_lp-1:0] rf_model [32];
  logic [dword_width_lp-1:0] rf_stale [32];

  // Expected outputs per cycle, indexed by cycle count modulo ring_lp
  logic                         exp_br_v      [ring_lp];
  logic                         exp_btaken    [ring_lp];
  logic [vaddr_width_lp-1:0]    exp_br_tgt    [ring_lp];
  logic                         exp_commit_v  [ring_lp];
  logic [vaddr_width_lp-1:0]    exp_commit_pc [ring_lp];
  logic                         exp_wb_v      [ring_lp];
  logic [reg_addr_width_lp-1:0] exp_wb_addr   [ring_lp];
  logic [dword_width_lp-1:0]    exp_wb_data   [ring_lp];

  int                        cyc;
  string                     test_name;
  logic [vaddr_width_lp-1:0] pc_cnt;

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  initial
  begin
    #(timeout_ns_lp);
    $display("Watchdog expired after %0d ns with tests still running", timeout_ns_lp);
    $display("Test failed");
    $fatal(1);
  end

  function automatic logic [dword_width_lp-1:0] rand_dword();
    return {$urandom, $urandom};
  endfunction

  // Signed, halfword aligned offset of up to 2 KiB
  function automatic logic [dword_width_lp-1:0] branch_offset();
    logic [31:0] r;
    r = $urandom;
    return {{52{r[11]}}, r[11:1], 1'b0};
  endfunction

  // x0 gets garbage from the register file port, the DUT must ignore it
  function automatic logic [dword_width_lp-1:0] stale_read(input int r);
    if (r == 0)
    begin
      return rand_dword() | 64'd1;
    end
    return rf_stale[r];
  endfunction

  function automatic logic [dword_width_lp-1:0] expected_result
  (
    input calc_op_e                  op,
    input logic [dword_width_lp-1:0] a,
    input logic [dword_width_lp-1:0] b,
    input logic [dword_width_lp-1:0] imm,
    input logic [vaddr_width_lp-1:0] pc
  );
    logic [dword_width_lp-1:0] r;
    logic [5:0]                sh;
    logic [vaddr_width_lp-1:0] link;
    sh   = b[5:0];
    link = pc + 39'd4;
    case (op)
      e_calc_add:  r = a + b;
      e_calc_addi: r = a + imm;
      e_calc_sub:  r = a - b;
      e_calc_and:  r = a & b;
      e_calc_or:   r = a | b;
      e_calc_xor:  r = a ^ b;
      e_calc_sll:  r = a << sh;
      e_calc_srl:  r = a >> sh;
      e_calc_sra:  r = $signed(a) >>> sh;
      e_calc_slt:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      e_calc_sltu: r = (a < b) ? 64'd1 : 64'd0;
      e_calc_mul:  r = a * b;
      e_calc_jal:  r = {25'd0, link};
      default:     r = '0;
    endcase
    return r;
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    assert (exp_val === act_val)
    else
    begin
      $display("** Error: [%s] %s expected %0h actual %0h", test_name, what, exp_val, act_val);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic clear_slot(input int s);
    exp_br_v[s]      = 1'b0;
    exp_btaken[s]    = 1'b0;
    exp_br_tgt[s]    = '0;
    exp_commit_v[s]  = 1'b0;
    exp_commit_pc[s] = '0;
    exp_wb_v[s]      = 1'b0;
    exp_wb_addr[s]   = '0;
    exp_wb_data[s]   = '0;
  endtask

  // One falling edge: check the outputs expected in this cycle
  task automatic advance();
    int s;
    @(negedge clk_i);
    cyc = cyc + 1;
    s   = cyc % ring_lp;
    check_value("br_v_o", exp_br_v[s], br_v_o);
    check_value("btaken_o", exp_btaken[s], btaken_o);
    if (exp_br_v[s])
    begin
      check_value("br_tgt_o", exp_br_tgt[s], br_tgt_o);
    end
    check_value("commit_v_o", exp_commit_v[s], commit_v_o);
    if (exp_commit_v[s])
    begin
      check_value("commit_pc_o", exp_commit_pc[s], commit_pc_o);
    end
    check_value("wb_v_o", exp_wb_v[s], wb_v_o);
    if (exp_wb_v[s])
    begin
      check_value("wb_addr_o", exp_wb_addr[s], wb_addr_o);
      check_value("wb_data_o", exp_wb_data[s], wb_data_o);
      // Register file catches up with the writeback
      rf_stale[exp_wb_addr[s]] = exp_wb_data[s];
    end
    clear_slot(s);
  endtask

  task automatic issue(input calc_op_e op, input int rd, input int rs1, input int rs2,
                       input logic [dword_width_lp-1:0] imm, input logic live,
                       input logic flush);
    logic [dword_width_lp-1:0] a;
    logic [dword_width_lp-1:0] b;
    logic                      is_ctrl;
    logic                      taken;
    int                        s;
    advance();
    a       = rf_model[rs1];
    b       = rf_model[rs2];
    is_ctrl = (op == e_calc_beq) || (op == e_calc_bne) || (op == e_calc_jal);
    taken   = (op == e_calc_jal) || ((op == e_calc_beq) && (a == b))
              || ((op == e_calc_bne) && (a != b));
    dispatch_v_i        = 1'b1;
    dispatch_op_i       = op;
    dispatch_pc_i       = pc_cnt;
    dispatch_rs1_addr_i = reg_addr_width_lp'(rs1);
    dispatch_rs2_addr_i = reg_addr_width_lp'(rs2);
    dispatch_rd_addr_i  = reg_addr_width_lp'(rd);
    dispatch_rs1_data_i = stale_read(rs1);
    dispatch_rs2_data_i = stale_read(rs2);
    dispatch_imm_i      = imm;
    flush_i             = flush;
    if (live)
    begin
      // Branch outcome in EX1, commit two edges later, writeback one after that
      s = (cyc + 1) % ring_lp;
      exp_br_v[s]   = is_ctrl;
      exp_btaken[s] = taken;
      exp_br_tgt[s] = taken ? pc_cnt + imm[vaddr_width_lp-1:0] : pc_cnt + 39'd4;
      s = (cyc + 3) % ring_lp;
      exp_commit_v[s]  = 1'b1;
      exp_commit_pc[s] = pc_cnt;
      if ((op != e_calc_beq) && (op != e_calc_bne) && (rd != 0))
      begin
        rf_model[rd]   = expected_result(op, a, b, imm, pc_cnt);
        s              = (cyc + 4) % ring_lp;
        exp_wb_v[s]    = 1'b1;
        exp_wb_addr[s] = reg_addr_width_lp'(rd);
        exp_wb_data[s] = rf_model[rd];
      end
    end
    pc_cnt = pc_cnt + 39'd4;
  endtask

  task automatic issue_live(input calc_op_e op, input int rd, input int rs1, input int rs2,
                            input logic [dword_width_lp-1:0] imm);
    issue(op, rd, rs1, rs2, imm, 1'b1, 1'b0);
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      advance();
      dispatch_v_i = 1'b0;
      flush_i      = 1'b0;
    end
  endtask

  task automatic test_reset_x0();
    test_name = "reset_x0";
    assert (!br_v_o && !commit_v_o && !wb_v_o)
    else
    begin
      $display("Branch, commit or writeback valid is high straight after reset");
      $display("Test failed");
      $fatal(1);
    end
    issue_live(e_calc_addi, 0, 0, 0, rand_dword());
    issue_live(e_calc_add, 17, 0, 0, 64'd0);
    issue_live(e_calc_or, 18, 17, 0, 64'd0);
    idle(5);
  endtask

  task automatic test_alu_chain();
    int       prev_rd;
    int       rd;
    calc_op_e op;
    test_name = "alu_chain";
    for (int r = 1; r <= 8; r++)
    begin
      issue_live(e_calc_addi, r, 0, 0, rand_dword());
    end
    prev_rd = 8;
    // Each op reads the previous result
    for (int i = 0; i < 24; i++)
    begin
      op = calc_op_e'($urandom_range(10, 0));
      rd = $urandom_range(8, 1);
      issue_live(op, rd, prev_rd, $urandom_range(8, 0), rand_dword());
      prev_rd = rd;
    end
    idle(5);
  endtask

  task automatic test_mul();
    test_name = "mul";
    issue_live(e_calc_mul, 9, 1, 2, 64'd0);
    issue_live(e_calc_addi, 11, 4, 0, rand_dword());
    // Two cycles after the mul, so the product is forwarded
    issue_live(e_calc_add, 10, 9, 11, 64'd0);
    issue_live(e_calc_mul, 12, 10, 3, 64'd0);
    issue_live(e_calc_addi, 13, 5, 0, rand_dword());
    issue_live(e_calc_sub, 19, 12, 9, 64'd0);
    idle(5);
    issue_live(e_calc_xor, 20, 9, 12, 64'd0);
    idle(5);
  endtask

  task automatic test_branch();
    logic [dword_width_lp-1:0] r;
    test_name = "branch";
    r         = rand_dword();
    pc_cnt    = {r[vaddr_width_lp-1:2], 2'b00};
    issue_live(e_calc_addi, 21, 1, 0, 64'd0);
    issue_live(e_calc_addi, 22, 1, 0, 64'd0);
    // rd is set on branches but must never be written
    issue_live(e_calc_beq, 15, 21, 22, branch_offset());
    issue_live(e_calc_beq, 15, 21, 2, branch_offset());
    issue_live(e_calc_bne, 15, 21, 22, branch_offset());
    issue_live(e_calc_bne, 15, 21, 2, branch_offset());
    issue_live(e_calc_jal, 14, 0, 0, branch_offset());
    issue_live(e_calc_add, 16, 14, 0, 64'd0);
    idle(5);
    issue_live(e_calc_add, 24, 15, 16, 64'd0);
    idle(5);
  endtask

  task automatic test_flush();
    test_name = "flush";
    issue_live(e_calc_add, 25, 1, 2, 64'd0);
    issue_live(e_calc_xor, 26, 25, 3, 64'd0);
    // Flush on the last of these kills it and the two before it
    issue(e_calc_addi, 27, 0, 0, rand_dword(), 1'b0, 1'b0);
    issue(e_calc_sub, 25, 26, 4, 64'd0, 1'b0, 1'b0);
    issue(e_calc_or, 26, 27, 25, 64'd0, 1'b0, 1'b1);
    issue_live(e_calc_add, 28, 25, 26, 64'd0);
    issue_live(e_calc_and, 29, 27, 28, 64'd0);
    idle(5);
  endtask

  initial
  begin
    void'($urandom(32'h33b1_267b));
    rst_i               = 1'b1;
    flush_i             = 1'b0;
    dispatch_v_i        = 1'b0;
    dispatch_op_i       = e_calc_add;
    dispatch_pc_i       = '0;
    dispatch_rs1_addr_i = '0;
    dispatch_rs2_addr_i = '0;
    dispatch_rd_addr_i  = '0;
    dispatch_rs1_data_i = '0;
    dispatch_rs2_data_i = '0;
    dispatch_imm_i      = '0;
    for (int r = 0; r < 32; r++)
    begin
      rf_model[r] = '0;
      rf_stale[r] = '0;
    end
    for (int s = 0; s < ring_lp; s++)
    begin
      clear_slot(s);
    end
    cyc       = 0;
    pc_cnt    = 39'h100;
    test_name = "init";
    repeat (reset_cycles_lp) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    test_reset_x0();
    test_alu_chain();
    test_mul();
    test_branch();
    test_flush();
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- hdl/calc_top.sv
/* Integer back end top: reservation register, EX1 pipes and stage pipe.
   No back-pressure; the dispatcher keeps mul dependents two cycles apart. */
`timescale 1ns/10ps

module calc_top
  import calc_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         flush_i,
  input  logic                         dispatch_v_i,
  input  calc_op_e                     dispatch_op_i,
  input  logic [vaddr_width_lp-1:0]    dispatch_pc_i,
  input  logic [reg_addr_width_lp-1:0] dispatch_rs1_addr_i,
  input  logic [reg_addr_width_lp-1:0] dispatch_rs2_addr_i,
  input  logic [reg_addr_width_lp-1:0] dispatch_rd_addr_i,
  input  logic [dword_width_lp-1:0]    dispatch_rs1_data_i,
  input  logic [dword_width_lp-1:0]    dispatch_rs2_data_i,
  input  logic [dword_width_lp-1:0]    dispatch_imm_i,
  output logic                         br_v_o,
  output logic                         btaken_o,
  output logic [vaddr_width_lp-1:0]    br_tgt_o,
  output logic                         commit_v_o,
  output logic [vaddr_width_lp-1:0]    commit_pc_o,
  output logic                         wb_v_o,
  output logic [reg_addr_width_lp-1:0] wb_addr_o,
  output logic [dword_width_lp-1:0]    wb_data_o
);

  logic [pipe_stage_els_lp:1]                        fwd_v;
  logic [pipe_stage_els_lp:1][reg_addr_width_lp-1:0] fwd_addr;
  logic [pipe_stage_els_lp:1][dword_width_lp-1:0]    fwd_data;

  logic [dword_width_lp-1:0] bypass_rs1;
  logic [dword_width_lp-1:0] bypass_rs2;

  // Reservation register (EX1)
  logic                         res_v_r;
  logic                         res_poison_r;
  calc_op_e                     res_op_r;
  logic [vaddr_width_lp-1:0]    res_pc_r;
  logic [reg_addr_width_lp-1:0] res_rd_r;
  logic [dword_width_lp-1:0]    res_rs1_r;
  logic [dword_width_lp-1:0]    res_rs2_r;
  logic [dword_width_lp-1:0]    res_imm_r;
  logic                         res_live;

  logic [dword_width_lp-1:0] int_data;
  logic [dword_width_lp-1:0] ctrl_data;
  logic [dword_width_lp-1:0] mul_data;

  calc_bypass u_bypass
  (
    .rs1_addr_i (dispatch_rs1_addr_i),
    .rs2_addr_i (dispatch_rs2_addr_i),
    .rs1_data_i (dispatch_rs1_data_i),
    .rs2_data_i (dispatch_rs2_data_i),
    .fwd_v_i    (fwd_v),
    .fwd_addr_i (fwd_addr),
    .fwd_data_i (fwd_data),
    .rs1_o      (bypass_rs1),
    .rs2_o      (bypass_rs2)
  );

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      res_v_r      <= 1'b0;
      res_poison_r <= 1'b0;
    end
    else
    begin
      res_v_r      <= dispatch_v_i;
      // A packet arriving with a flush is younger than the redirect
      res_poison_r <= flush_i;
    end
    res_op_r  <= dispatch_op_i;
    res_pc_r  <= dispatch_pc_i;
    res_rd_r  <= dispatch_rd_addr_i;
    res_rs1_r <= bypass_rs1;
    res_rs2_r <= bypass_rs2;
    res_imm_r <= dispatch_imm_i;
  end

  assign res_live = res_v_r & ~res_poison_r;

  calc_pipe_ctrl u_pipe_ctrl
  (
    .v_i      (res_live),
    .op_i     (res_op_r),
    .pc_i     (res_pc_r),
    .rs1_i    (res_rs1_r),
    .rs2_i    (res_rs2_r),
    .imm_i    (res_imm_r),
    .br_v_o   (br_v_o),
    .btaken_o (btaken_o),
    .br_tgt_o (br_tgt_o),
    .data_o   (ctrl_data)
  );

  calc_pipe_int u_pipe_int
  (
    .op_i   (res_op_r),
    .rs1_i  (res_rs1_r),
    .rs2_i  (res_rs2_r),
    .imm_i  (res_imm_r),
    .data_o (int_data)
  );

  // Product appears while the mul sits in stage 0
  calc_pipe_mul u_pipe_mul
  (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .rs1_i  (res_rs1_r),
    .rs2_i  (res_rs2_r),
    .data_o (mul_data)
  );

  calc_stage_pipe u_stage_pipe
  (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .flush_i       (flush_i),
    .isd_v_i       (res_live),
    .isd_op_i      (res_op_r),
    .isd_pc_i      (res_pc_r),
    .isd_rd_addr_i (res_rd_r),
    .int_data_i    (int_data),
    .ctrl_data_i   (ctrl_data),
    .mul_data_i    (mul_data),
    .fwd_v_o       (fwd_v),
    .fwd_addr_o    (fwd_addr),
    .fwd_data_o    (fwd_data),
    .commit_v_o    (commit_v_o),
    .commit_pc_o   (commit_pc_o),
    .wb_v_o        (wb_v_o),
    .wb_addr_o     (wb_addr_o),
    .wb_data_o     (wb_data_o)
  );

  // The product reaches the bypass only two dispatch cycles after the mul
  assert property (@(posedge clk_i) disable iff (rst_i)
    (dispatch_v_i && !flush_i && res_live && (res_op_r == e_calc_mul) && (res_rd_r != '0))
    |-> ((dispatch_rs1_addr_i != res_rd_r) && (dispatch_rs2_addr_i != res_rd_r)))
    else $error("packet reads a mul result one cycle after the mul");

endmodule

//--- hdl/calc_stage_pipe.sv
/* Calc, completion and poison stages after EX1: commit reads stage 1, writeback stage 2.
   Flush kills packets entering stage 0 and stage 1; stage 2 is already committed. */
`timescale 1ns/10ps

module calc_stage_pipe
  import calc_pkg::*;
(
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  logic                                              flush_i,
  input  logic                                              isd_v_i,
  input  calc_op_e                                          isd_op_i,
  input  logic [vaddr_width_lp-1:0]                         isd_pc_i,
  input  logic [reg_addr_width_lp-1:0]                      isd_rd_addr_i,
  input  logic [dword_width_lp-1:0]                         int_data_i,
  input  logic [dword_width_lp-1:0]                         ctrl_data_i,
  input  logic [dword_width_lp-1:0]                         mul_data_i,
  output logic [pipe_stage_els_lp:1]                        fwd_v_o,
  output logic [pipe_stage_els_lp:1][reg_addr_width_lp-1:0] fwd_addr_o,
  output logic [pipe_stage_els_lp:1][dword_width_lp-1:0]    fwd_data_o,
  output logic                                              commit_v_o,
  output logic [vaddr_width_lp-1:0]                         commit_pc_o,
  output logic                                              wb_v_o,
  output logic [reg_addr_width_lp-1:0]                      wb_addr_o,
  output logic [dword_width_lp-1:0]                         wb_data_o
);

  logic     [pipe_stage_els_lp-1:0]                         st_v_r, st_v_n;
  logic     [pipe_stage_els_lp-1:0]                         st_poison_r, st_poison_n;
  logic     [pipe_stage_els_lp-1:0]                         st_w_r, st_w_n;
  calc_op_e [pipe_stage_els_lp-1:0]                         st_op_r, st_op_n;
  logic     [pipe_stage_els_lp-1:0][vaddr_width_lp-1:0]     st_pc_r, st_pc_n;
  logic     [pipe_stage_els_lp-1:0][reg_addr_width_lp-1:0]  st_rd_r, st_rd_n;
  logic     [pipe_stage_els_lp-1:0][dword_width_lp-1:0]     comp_r, comp_n;

  logic mul_merge;

  assign mul_merge = st_v_r[0] & (st_op_r[0] == e_calc_mul);

  always_comb
  begin
    // Issue info enters stage 0, everything else shifts down
    st_v_n[0]      = isd_v_i;
    st_op_n[0]     = isd_op_i;
    st_pc_n[0]     = isd_pc_i;
    st_rd_n[0]     = isd_rd_addr_i;
    st_w_n[0]      = calc_op_writes_rd(isd_op_i) & (isd_rd_addr_i != '0);
    st_poison_n[0] = flush_i;
    for (int i = 1; i < pipe_stage_els_lp; i++)
    begin
      st_v_n[i]      = st_v_r[i-1];
      st_op_n[i]     = st_op_r[i-1];
      st_pc_n[i]     = st_pc_r[i-1];
      st_rd_n[i]     = st_rd_r[i-1];
      st_w_n[i]      = st_w_r[i-1];
      st_poison_n[i] = st_poison_r[i-1];
      comp_n[i]      = comp_r[i-1];
    end
    // Last chance to kill before commit
    st_poison_n[1] = st_poison_r[0] | flush_i;

    // EX1 results land in stage 0, the product one stage later
    comp_n[0] = calc_op_is_ctrl(isd_op_i) ? ctrl_data_i : int_data_i;
    if (mul_merge)
    begin
      comp_n[1] = mul_data_i;
    end
  end

  // Forwarding slices from next-state values
  always_comb
  begin
    for (int s = 1; s <= pipe_stage_els_lp; s++)
    begin
      fwd_v_o[s]    = st_v_n[s-1] & st_w_n[s-1] & ~st_poison_n[s-1];
      fwd_addr_o[s] = st_rd_n[s-1];
      fwd_data_o[s] = comp_n[s-1];
    end
    // Product not ready yet
    if (st_op_n[0] == e_calc_mul)
    begin
      fwd_v_o[1] = 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      st_v_r      <= '0;
      st_poison_r <= '0;
    end
    else
    begin
      st_v_r      <= st_v_n;
      st_poison_r <= st_poison_n;
    end
    st_op_r <= st_op_n;
    st_pc_r <= st_pc_n;
    st_rd_r <= st_rd_n;
    st_w_r  <= st_w_n;
    comp_r  <= comp_n;
  end

  assign commit_v_o  = st_v_r[1] & ~st_poison_r[1];
  assign commit_pc_o = st_pc_r[1];

  assign wb_v_o    = st_v_r[pipe_stage_els_lp-1] & st_w_r[pipe_stage_els_lp-1]
                     & ~st_poison_r[pipe_stage_els_lp-1];
  assign wb_addr_o = st_rd_r[pipe_stage_els_lp-1];
  assign wb_data_o = comp_r[pipe_stage_els_lp-1];

endmodule

//--- hdl/calc_pipe_mul.sv
/* Two-cycle multiplier returning the low 64 bits of the product.
   Operands are sampled every cycle; the stage pipe picks the valid slot. */
`timescale 1ns/10ps

module calc_pipe_mul
  import calc_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [dword_width_lp-1:0] rs1_i,
  input  logic [dword_width_lp-1:0] rs2_i,
  output logic [dword_width_lp-1:0] data_o
);

  logic [dword_width_lp-1:0] rs1_r;
  logic [dword_width_lp-1:0] rs2_r;

  // Operands captured at the end of EX1
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rs1_r <= '0;
      rs2_r <= '0;
    end
    else
    begin
      rs1_r <= rs1_i;
      rs2_r <= rs2_i;
    end
  end

  // Low half is identical for signed and unsigned operands
  assign data_o = rs1_r * rs2_r;

endmodule

//--- hdl/calc_pipe_int.sv
/* Single-cycle integer ALU. Opcodes outside the int group return zero.
   Shift amount is the low six bits of the second operand. */
`timescale 1ns/10ps

module calc_pipe_int
  import calc_pkg::*;
(
  input  calc_op_e                  op_i,
  input  logic [dword_width_lp-1:0] rs1_i,
  input  logic [dword_width_lp-1:0] rs2_i,
  input  logic [dword_width_lp-1:0] imm_i,
  output logic [dword_width_lp-1:0] data_o
);

  logic [dword_width_lp-1:0]         opb;
  logic [$clog2(dword_width_lp)-1:0] shamt;
  logic                              lt_s;
  logic                              lt_u;

  // Immediate form only for addi
  assign opb   = (op_i == e_calc_addi) ? imm_i : rs2_i;
  assign shamt = opb[$clog2(dword_width_lp)-1:0];

  assign lt_s = ($signed(rs1_i) < $signed(opb));
  assign lt_u = (rs1_i < opb);

  always_comb
  begin
    case (op_i)
      e_calc_add, e_calc_addi:
        data_o = rs1_i + opb;
      e_calc_sub:
        data_o = rs1_i - opb;
      e_calc_and:
        data_o = rs1_i & opb;
      e_calc_or:
        data_o = rs1_i | opb;
      e_calc_xor:
        data_o = rs1_i ^ opb;
      e_calc_sll:
        data_o = rs1_i << shamt;
      e_calc_srl:
        data_o = rs1_i >> shamt;
      e_calc_sra:
        data_o = $signed(rs1_i) >>> shamt;
      e_calc_slt:
        data_o = {{(dword_width_lp-1){1'b0}}, lt_s};
      e_calc_sltu:
        data_o = {{(dword_width_lp-1){1'b0}}, lt_u};
      default:
        data_o = '0;
    endcase
  end

endmodule

//--- hdl/calc_pipe_ctrl.sv
/* Branch and jump resolution in EX1; outputs are combinational from the
   reservation register. Link value is pc+4 zero-extended to 64 bits. */
`timescale 1ns/10ps

module calc_pipe_ctrl
  import calc_pkg::*;
(
  input  logic                      v_i,
  input  calc_op_e                  op_i,
  input  logic [vaddr_width_lp-1:0] pc_i,
  input  logic [dword_width_lp-1:0] rs1_i,
  input  logic [dword_width_lp-1:0] rs2_i,
  input  logic [dword_width_lp-1:0] imm_i,
  output logic                      br_v_o,
  output logic                      btaken_o,
  output logic [vaddr_width_lp-1:0] br_tgt_o,
  output logic [dword_width_lp-1:0] data_o
);

  logic                      operands_eq;
  logic                      cond_met;
  logic [vaddr_width_lp-1:0] taken_tgt;
  logic [vaddr_width_lp-1:0] next_pc;

  assign operands_eq = (rs1_i == rs2_i);

  always_comb
  begin
    case (op_i)
      e_calc_beq: cond_met = operands_eq;
      e_calc_bne: cond_met = ~operands_eq;
      e_calc_jal: cond_met = 1'b1;
      default:    cond_met = 1'b0;
    endcase
  end

  // Offset is truncated to the pc width
  assign taken_tgt = pc_i + imm_i[vaddr_width_lp-1:0];
  assign next_pc   = pc_i + vaddr_width_lp'(instr_bytes_lp);

  assign br_v_o   = v_i & calc_op_is_ctrl(op_i);
  assign btaken_o = br_v_o & cond_met;
  assign br_tgt_o = btaken_o ? taken_tgt : next_pc;
  assign data_o   = dword_width_lp'(next_pc);

  // A redirect must land on a halfword boundary
  always_comb
  begin
    assert final (!br_v_o || !br_tgt_o[0])
      else $error("branch or jump target is not halfword aligned");
  end

endmodule

//--- hdl/calc_bypass.sv
/* Operand forwarding from the completion pipe next-state slices.
   Slice 1 is the youngest; x0 always reads zero. */
`timescale 1ns/10ps

module calc_bypass
  import calc_pkg::*;
(
  input  logic [reg_addr_width_lp-1:0]                        rs1_addr_i,
  input  logic [reg_addr_width_lp-1:0]                        rs2_addr_i,
  input  logic [dword_width_lp-1:0]                           rs1_data_i,
  input  logic [dword_width_lp-1:0]                           rs2_data_i,
  input  logic [pipe_stage_els_lp:1]                          fwd_v_i,
  input  logic [pipe_stage_els_lp:1][reg_addr_width_lp-1:0]   fwd_addr_i,
  input  logic [pipe_stage_els_lp:1][dword_width_lp-1:0]      fwd_data_i,
  output logic [dword_width_lp-1:0]                           rs1_o,
  output logic [dword_width_lp-1:0]                           rs2_o
);

  function automatic logic [dword_width_lp-1:0] pick_src
  (
    input logic [reg_addr_width_lp-1:0]                      addr,
    input logic [dword_width_lp-1:0]                         rf_data,
    input logic [pipe_stage_els_lp:1]                        v,
    input logic [pipe_stage_els_lp:1][reg_addr_width_lp-1:0] fwd_addr,
    input logic [pipe_stage_els_lp:1][dword_width_lp-1:0]    fwd_data
  );
    logic [dword_width_lp-1:0] sel;
    sel = rf_data;
    // Walk from oldest to youngest so the youngest match wins
    for (int s = pipe_stage_els_lp; s >= 1; s--)
    begin
      if (v[s] && (fwd_addr[s] == addr))
      begin
        sel = fwd_data[s];
      end
    end
    if (addr == '0)
    begin
      sel = '0;
    end
    return sel;
  endfunction

  always_comb
  begin
    rs1_o = pick_src(rs1_addr_i, rs1_data_i, fwd_v_i, fwd_addr_i, fwd_data_i);
    rs2_o = pick_src(rs2_addr_i, rs2_data_i, fwd_v_i, fwd_addr_i, fwd_data_i);
  end

endmodule

//--- hdl/calc_pkg.sv
/* Shared widths, stage counts and opcodes for the integer execution back end.
   Opcode encoding is internal to the back end; decode happens upstream. */
package calc_pkg;

  // Datapath widths
  localparam int dword_width_lp    = 64;
  localparam int vaddr_width_lp    = 39;
  localparam int reg_addr_width_lp = 5;

  // Stages after EX1: completion 0, commit at 1, writeback at 2
  localparam int pipe_stage_els_lp = 3;

  // Link and fall-through step
  localparam int instr_bytes_lp = 4;

  typedef enum logic [3:0]
  {
    e_calc_add  = 4'h0,
    e_calc_addi = 4'h1,
    e_calc_sub  = 4'h2,
    e_calc_and  = 4'h3,
    e_calc_or   = 4'h4,
    e_calc_xor  = 4'h5,
    e_calc_sll  = 4'h6,
    e_calc_srl  = 4'h7,
    e_calc_sra  = 4'h8,
    e_calc_slt  = 4'h9,
    e_calc_sltu = 4'ha,
    e_calc_mul  = 4'hb,
    e_calc_beq  = 4'hc,
    e_calc_bne  = 4'hd,
    e_calc_jal  = 4'he
  } calc_op_e;

  // Branches and jumps go to the ctrl pipe
  function automatic logic calc_op_is_ctrl(input calc_op_e op);
    logic is_ctrl;
    is_ctrl = (op == e_calc_beq) || (op == e_calc_bne) || (op == e_calc_jal);
    return is_ctrl;
  endfunction

  // Only conditional branches leave rd untouched
  function automatic logic calc_op_writes_rd(input calc_op_e op);
    logic writes;
    writes = (op != e_calc_beq) && (op != e_calc_bne);
    return writes;
  endfunction

endpackage
